// ==== aether_isa_pkg.sv ====
package aether_isa_pkg;

  // --------------------
  // Instruction fields
  // --------------------

  // Opcode width
  localparam int OPC_W  = 4;
  // Subcommand or register index
  localparam int PRM1_W = 4;
  // Operand width
  localparam int PRM2_W = 16;
  // Save address is param1 above param2
  localparam int ADDR_W = PRM1_W + PRM2_W;

  // --------------------
  // Opcodes
  // --------------------
  typedef enum logic [OPC_W-1:0] {
    NOP = 4'h0,
    RST = 4'h1,
    RDR = 4'h2,
    WRR = 4'h3,
    LDW = 4'h4,
    CNV = 4'h5,
    DNS = 4'h6,
    LIP = 4'h7
  } opcode_e;

  // --------------------
  // Subcommands
  // --------------------

  // Reset targets, carried in param1
  typedef enum logic [PRM1_W-1:0] {
    RST_FULL = 4'h0,
    RST_CWGT = 4'h1,
    RST_CONV = 4'h2,
    RST_DWGT = 4'h3,
    RST_DENS = 4'h4,
    RST_REGS = 4'h5
  } rst_sub_e;

  // Weight load steps
  typedef enum logic [PRM1_W-1:0] {
    LDW_CWGT = 4'h0,
    LDW_DWGT = 4'h1,
    LDW_STRT = 4'h2,
    LDW_CONT = 4'h3,
    LDW_MOVE = 4'h4
  } ldw_sub_e;

  // Input load steps
  typedef enum logic [PRM1_W-1:0] {
    LIP_STRT = 4'h0,
    LIP_CONT = 4'h1
  } lip_sub_e;

endpackage

// ==== aether_reg_pkg.sv ====
package aether_reg_pkg;

  // Register width and index width
  localparam int REG_W     = 16;
  localparam int REG_IDX_W = 4;

  // --------------------
  // Register map
  // --------------------
  typedef enum logic [REG_IDX_W-1:0] {
    REG_VERSN = 4'h0,
    REG_HWRID = 4'h1,
    REG_MEMUP = 4'h2,
    REG_MSTRT = 4'h3,
    REG_MENDD = 4'h4,
    REG_BCFG1 = 4'h5,
    REG_BCFG2 = 4'h6,
    REG_BCFG3 = 4'h7,
    REG_CPRM1 = 4'h8,
    REG_STATS = 4'h9
  } reg_idx_e;

  // Read-only identification
  localparam logic [REG_W-1:0] VERSION_VAL = 16'h0103;
  localparam logic [REG_W-1:0] HWID_VAL    = 16'hae71;

  // Defaults for the writable registers
  localparam logic [REG_W-1:0] RESET_DEFAULT_MEMUP = 16'h0000;
  localparam logic [REG_W-1:0] RESET_DEFAULT_MSTRT = 16'h0000;
  localparam logic [REG_W-1:0] RESET_DEFAULT_MENDD = 16'hffff;
  localparam logic [REG_W-1:0] RESET_DEFAULT_BCFG1 = 16'h0010;
  localparam logic [REG_W-1:0] RESET_DEFAULT_BCFG2 = 16'h0020;
  localparam logic [REG_W-1:0] RESET_DEFAULT_BCFG3 = 16'h0040;
  localparam logic [REG_W-1:0] RESET_DEFAULT_CPRM1 = 16'h0000;
  localparam logic [REG_W-1:0] RESET_DEFAULT_STATS = 16'h0000;

  // CPRM1 bit, convolution result goes to RAM
  localparam int CPRM1_SAVE_BIT = 0;

  // Sticky done bits in STATS
  localparam int STATS_CNV_BIT = 0;
  localparam int STATS_DNS_BIT = 1;
  localparam int STATS_LDW_BIT = 2;
  localparam logic [REG_W-1:0] STATS_STICKY_MASK = 16'h0007;

  // Memory command towards the RAM controller
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'b00,
    MEM_WRITE = 2'b01,
    MEM_READ  = 2'b10
  } mem_cmd_e;

endpackage

// ==== aether_cmd_frontend.sv ====
`timescale 1ns/1ps

module aether_cmd_frontend
  import aether_isa_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host handshake
  input  logic              req_i,
  input  opcode_e           instr_i,
  input  logic [PRM1_W-1:0] param1_i,
  input  logic [PRM2_W-1:0] param2_i,
  output logic              ack_o,
  output logic [15:0]       rdata_o,
  output logic              err_o,
  // Issued command towards the decoder
  output opcode_e           issue_op_o,
  output logic [PRM1_W-1:0] issue_p1_o,
  output logic [PRM2_W-1:0] issue_p2_o,
  // Decoder response
  input  logic [15:0]       rd_data_i,
  input  logic              dec_err_i
);

  // --------------------
  // Handshake FSM
  // --------------------
  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    HOLD
  } state_e;

  state_e            state_q;
  state_e            state_d;
  opcode_e           op_q;
  logic [PRM1_W-1:0] p1_q;
  logic [PRM2_W-1:0] p2_q;
  logic [15:0]       rdata_q;
  logic              err_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait for a new request
      IDLE: if (req_i) state_d = EXEC;
      // Single issue cycle
      EXEC: state_d = HOLD;
      // Hold ack until host drops req
      HOLD: if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command capture on accept
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      op_q <= instr_i;
      p1_q <= param1_i;
      p2_q <= param2_i;
    end
  end

  // Response captured at end of EXEC
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (state_q == EXEC) begin
      rdata_q <= rd_data_i;
      err_q   <= dec_err_i;
    end
  end

  // Only EXEC carries a real opcode
  assign issue_op_o = (state_q == EXEC) ? op_q : NOP;
  assign issue_p1_o = (state_q == EXEC) ? p1_q : '0;
  assign issue_p2_o = (state_q == EXEC) ? p2_q : '0;

  assign ack_o   = (state_q == HOLD);
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

// ==== aether_instr_decoder.sv ====
`timescale 1ns/1ps

module aether_instr_decoder
  import aether_isa_pkg::*;
  import aether_reg_pkg::*;
(
  // Issued command
  input  opcode_e           op_i,
  input  logic [PRM1_W-1:0] p1_i,
  input  logic [PRM2_W-1:0] p2_i,
  // Register values
  input  logic [REG_W-1:0]  versn_i,
  input  logic [REG_W-1:0]  hwrid_i,
  input  logic [REG_W-1:0]  memup_i,
  input  logic [REG_W-1:0]  mstrt_i,
  input  logic [REG_W-1:0]  mendd_i,
  input  logic [REG_W-1:0]  bcfg1_i,
  input  logic [REG_W-1:0]  bcfg2_i,
  input  logic [REG_W-1:0]  bcfg3_i,
  input  logic [REG_W-1:0]  cprm1_i,
  input  logic [REG_W-1:0]  stats_i,
  // Read data, error, register write
  output logic [REG_W-1:0]  rd_data_o,
  output logic              err_o,
  output logic              wr_en_o,
  output reg_idx_e          wr_idx_o,
  output logic [REG_W-1:0]  wr_data_o,
  output logic              stats_rd_o,
  // Reset pulses
  output logic              rst_cwgt_o,
  output logic              rst_conv_o,
  output logic              rst_dwgt_o,
  output logic              rst_dens_o,
  output logic              rst_regs_o,
  output logic              rst_full_o,
  // Weight load pulses
  output logic              ldw_cwgt_o,
  output logic              ldw_dwgt_o,
  output logic              ldw_strt_o,
  output logic              ldw_cont_o,
  output logic              ldw_move_o,
  // Compute
  output logic              cnv_run_o,
  output logic [ADDR_W-1:0] cnv_save_addr_o,
  output logic              dns_run_o,
  output logic [ADDR_W-1:0] dns_save_addr_o,
  // Input load pulses
  output logic              lip_strt_o,
  output logic              lip_cont_o,
  output mem_cmd_e          mem_command_o
);

  // Per-opcode error flags
  logic rst_err;
  logic rdr_err;
  logic wrr_err;
  logic ldw_err;
  logic lip_err;
  // LDW memory requests
  logic ldw_mem_rd;
  logic ldw_mem_wr;

  // --------------------
  // RST
  // --------------------
  always_comb begin
    {rst_cwgt_o, rst_conv_o, rst_dwgt_o, rst_dens_o, rst_regs_o, rst_full_o} = 6'b0;
    rst_err = 1'b0;
    if (op_i == RST) begin
      case (p1_i)
        RST_CWGT: rst_cwgt_o = 1'b1;
        RST_CONV: rst_conv_o = 1'b1;
        RST_DWGT: rst_dwgt_o = 1'b1;
        RST_DENS: rst_dens_o = 1'b1;
        RST_REGS: rst_regs_o = 1'b1;
        default: begin
          // Full reset, unknown target falls back to it
          {rst_cwgt_o, rst_conv_o, rst_dwgt_o, rst_dens_o, rst_regs_o, rst_full_o} = 6'h3f;
          rst_err = (p1_i != RST_FULL);
        end
      endcase
    end
  end

  // --------------------
  // RDR
  // --------------------
  always_comb begin
    // Status shows when idle
    rd_data_o  = stats_i;
    stats_rd_o = 1'b0;
    rdr_err    = 1'b0;
    if (op_i == RDR) begin
      case (p1_i)
        REG_VERSN: rd_data_o = versn_i;
        REG_HWRID: rd_data_o = hwrid_i;
        REG_MEMUP: rd_data_o = memup_i;
        REG_MSTRT: rd_data_o = mstrt_i;
        REG_MENDD: rd_data_o = mendd_i;
        REG_BCFG1: rd_data_o = bcfg1_i;
        REG_BCFG2: rd_data_o = bcfg2_i;
        REG_BCFG3: rd_data_o = bcfg3_i;
        REG_CPRM1: rd_data_o = cprm1_i;
        REG_STATS: stats_rd_o = 1'b1; // clear on read
        default: begin
          rd_data_o = '0;
          rdr_err   = 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // WRR
  // --------------------
  assign wr_idx_o  = reg_idx_e'(p1_i);
  assign wr_data_o = p2_i;

  always_comb begin
    wr_en_o = 1'b0;
    wrr_err = 1'b0;
    if (op_i == WRR) begin
      case (p1_i)
        REG_MEMUP, REG_MSTRT, REG_MENDD, REG_BCFG1, REG_BCFG2,
        REG_BCFG3, REG_CPRM1, REG_STATS: wr_en_o = 1'b1;
        // Read-only or out of range
        default: wrr_err = 1'b1;
      endcase
    end
  end

  // --------------------
  // LDW
  // --------------------
  always_comb begin
    {ldw_cwgt_o, ldw_dwgt_o, ldw_strt_o, ldw_cont_o, ldw_move_o} = 5'b0;
    ldw_mem_rd = 1'b0;
    ldw_mem_wr = 1'b0;
    ldw_err    = 1'b0;
    if (op_i == LDW) begin
      case (p1_i)
        LDW_CWGT: {ldw_cwgt_o, ldw_mem_rd} = 2'b11;
        LDW_DWGT: {ldw_dwgt_o, ldw_mem_rd} = 2'b11;
        LDW_STRT: ldw_strt_o = 1'b1;
        LDW_CONT: ldw_cont_o = 1'b1;
        LDW_MOVE: {ldw_move_o, ldw_mem_wr} = 2'b11;
        default:  ldw_err = 1'b1;
      endcase
    end
  end

  // --------------------
  // CNV, DNS, LIP
  // --------------------
  assign cnv_run_o       = (op_i == CNV);
  assign cnv_save_addr_o = cnv_run_o ? {p1_i, p2_i} : '0;

  // Dense only runs with param1 zero
  assign dns_run_o       = (op_i == DNS) && (p1_i == '0);
  assign dns_save_addr_o = dns_run_o ? {p1_i, p2_i} : '0;

  always_comb begin
    lip_strt_o = 1'b0;
    lip_cont_o = 1'b0;
    lip_err    = 1'b0;
    if (op_i == LIP) begin
      case (p1_i)
        LIP_STRT: lip_strt_o = 1'b1;
        LIP_CONT: lip_cont_o = 1'b1;
        default:  lip_err = 1'b1;
      endcase
    end
  end

  // --------------------
  // Memory command
  // --------------------
  always_comb begin
    // Write beats read
    if (ldw_mem_wr || (cnv_run_o && cprm1_i[CPRM1_SAVE_BIT]) || (op_i == DNS)) begin
      mem_command_o = MEM_WRITE;
    end else if (ldw_mem_rd) begin
      mem_command_o = MEM_READ;
    end else begin
      mem_command_o = MEM_IDLE;
    end
  end

  assign err_o = rst_err | rdr_err | wrr_err | ldw_err | lip_err;

endmodule

// ==== aether_reg_file.sv ====
`timescale 1ns/1ps

module aether_reg_file
  import aether_reg_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Register write port
  input  logic             wr_en_i,
  input  reg_idx_e         wr_idx_i,
  input  logic [REG_W-1:0] wr_data_i,
  // Soft reset and clear on read
  input  logic             rst_regs_i,
  input  logic             stats_rd_i,
  // Engine done pulses
  input  logic             cnv_done_i,
  input  logic             dns_done_i,
  input  logic             ldw_done_i,
  // Register values
  output logic [REG_W-1:0] versn_o,
  output logic [REG_W-1:0] hwrid_o,
  output logic [REG_W-1:0] memup_o,
  output logic [REG_W-1:0] mstrt_o,
  output logic [REG_W-1:0] mendd_o,
  output logic [REG_W-1:0] bcfg1_o,
  output logic [REG_W-1:0] bcfg2_o,
  output logic [REG_W-1:0] bcfg3_o,
  output logic [REG_W-1:0] cprm1_o,
  output logic [REG_W-1:0] stats_o
);

  logic [REG_W-1:0] memup_q;
  logic [REG_W-1:0] mstrt_q;
  logic [REG_W-1:0] mendd_q;
  logic [REG_W-1:0] bcfg1_q;
  logic [REG_W-1:0] bcfg2_q;
  logic [REG_W-1:0] bcfg3_q;
  logic [REG_W-1:0] cprm1_q;
  logic [REG_W-1:0] stats_q;
  logic [REG_W-1:0] stats_d;
  // Done pulses placed on their bits
  logic [REG_W-1:0] done_vec;

  // --------------------
  // Config registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || rst_regs_i) begin
      memup_q <= RESET_DEFAULT_MEMUP;
      mstrt_q <= RESET_DEFAULT_MSTRT;
      mendd_q <= RESET_DEFAULT_MENDD;
      bcfg1_q <= RESET_DEFAULT_BCFG1;
      bcfg2_q <= RESET_DEFAULT_BCFG2;
      bcfg3_q <= RESET_DEFAULT_BCFG3;
      cprm1_q <= RESET_DEFAULT_CPRM1;
    end else if (wr_en_i) begin
      case (wr_idx_i)
        REG_MEMUP: memup_q <= wr_data_i;
        REG_MSTRT: mstrt_q <= wr_data_i;
        REG_MENDD: mendd_q <= wr_data_i;
        REG_BCFG1: bcfg1_q <= wr_data_i;
        REG_BCFG2: bcfg2_q <= wr_data_i;
        REG_BCFG3: bcfg3_q <= wr_data_i;
        REG_CPRM1: cprm1_q <= wr_data_i;
        // STATS handled below, others read-only
        default: ;
      endcase
    end
  end

  // --------------------
  // Sticky status
  // --------------------
  always_comb begin
    done_vec                = '0;
    done_vec[STATS_CNV_BIT] = cnv_done_i;
    done_vec[STATS_DNS_BIT] = dns_done_i;
    done_vec[STATS_LDW_BIT] = ldw_done_i;
  end

  always_comb begin
    stats_d = stats_q;
    if (rst_regs_i) begin
      stats_d = RESET_DEFAULT_STATS;
    end else if (wr_en_i && wr_idx_i == REG_STATS) begin
      stats_d = wr_data_i;
    end else if (stats_rd_i) begin
      stats_d = stats_q & ~STATS_STICKY_MASK;
    end
    // New done event wins over clear
    stats_d = stats_d | done_vec;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stats_q <= RESET_DEFAULT_STATS;
    end else begin
      stats_q <= stats_d;
    end
  end

  assign versn_o = VERSION_VAL;
  assign hwrid_o = HWID_VAL;
  assign memup_o = memup_q;
  assign mstrt_o = mstrt_q;
  assign mendd_o = mendd_q;
  assign bcfg1_o = bcfg1_q;
  assign bcfg2_o = bcfg2_q;
  assign bcfg3_o = bcfg3_q;
  assign cprm1_o = cprm1_q;
  // Same-cycle done shows in a read
  assign stats_o = stats_q | done_vec;

endmodule

// ==== aether_ctrl_top.sv ====
`timescale 1ns/1ps

module aether_ctrl_top
  import aether_isa_pkg::*;
  import aether_reg_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host handshake
  input  logic              req_i,
  input  opcode_e           instr_i,
  input  logic [PRM1_W-1:0] param1_i,
  input  logic [PRM2_W-1:0] param2_i,
  output logic              ack_o,
  output logic [REG_W-1:0]  rdata_o,
  output logic              err_o,
  // Engine done events
  input  logic              cnv_done_i,
  input  logic              dns_done_i,
  input  logic              ldw_done_i,
  // Engine actions
  output logic              rst_cwgt_o,
  output logic              rst_conv_o,
  output logic              rst_dwgt_o,
  output logic              rst_dens_o,
  output logic              rst_regs_o,
  output logic              rst_full_o,
  output logic              ldw_cwgt_o,
  output logic              ldw_dwgt_o,
  output logic              ldw_strt_o,
  output logic              ldw_cont_o,
  output logic              ldw_move_o,
  output logic              cnv_run_o,
  output logic [ADDR_W-1:0] cnv_save_addr_o,
  output logic              dns_run_o,
  output logic [ADDR_W-1:0] dns_save_addr_o,
  output logic              lip_strt_o,
  output logic              lip_cont_o,
  output mem_cmd_e          mem_command_o
);

  // Issued command
  opcode_e           issue_op;
  logic [PRM1_W-1:0] issue_p1;
  logic [PRM2_W-1:0] issue_p2;
  // Decoder to front end
  logic [REG_W-1:0]  rd_data;
  logic              dec_err;
  // Decoder to register file
  logic              wr_en;
  reg_idx_e          wr_idx;
  logic [REG_W-1:0]  wr_data;
  logic              stats_rd;
  // Register values
  logic [REG_W-1:0]  versn, hwrid, memup, mstrt, mendd;
  logic [REG_W-1:0]  bcfg1, bcfg2, bcfg3, cprm1, stats;

  aether_cmd_frontend i_aether_cmd_frontend (
    .clk_i, .rst_n_i, .req_i, .instr_i, .param1_i, .param2_i,
    .ack_o, .rdata_o, .err_o,
    .issue_op_o (issue_op),
    .issue_p1_o (issue_p1),
    .issue_p2_o (issue_p2),
    .rd_data_i  (rd_data),
    .dec_err_i  (dec_err)
  );

  // Pulses already qualified by the NOP outside EXEC
  aether_instr_decoder i_aether_instr_decoder (
    .op_i (issue_op), .p1_i (issue_p1), .p2_i (issue_p2),
    .versn_i (versn), .hwrid_i (hwrid), .memup_i (memup), .mstrt_i (mstrt),
    .mendd_i (mendd), .bcfg1_i (bcfg1), .bcfg2_i (bcfg2), .bcfg3_i (bcfg3),
    .cprm1_i (cprm1), .stats_i (stats),
    .rd_data_o (rd_data), .err_o (dec_err),
    .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_data_o (wr_data), .stats_rd_o (stats_rd),
    .rst_cwgt_o, .rst_conv_o, .rst_dwgt_o, .rst_dens_o, .rst_regs_o, .rst_full_o,
    .ldw_cwgt_o, .ldw_dwgt_o, .ldw_strt_o, .ldw_cont_o, .ldw_move_o,
    .cnv_run_o, .cnv_save_addr_o, .dns_run_o, .dns_save_addr_o,
    .lip_strt_o, .lip_cont_o, .mem_command_o
  );

  aether_reg_file i_aether_reg_file (
    .clk_i, .rst_n_i,
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_data_i (wr_data),
    .rst_regs_i (rst_regs_o), .stats_rd_i (stats_rd),
    .cnv_done_i, .dns_done_i, .ldw_done_i,
    .versn_o (versn), .hwrid_o (hwrid), .memup_o (memup), .mstrt_o (mstrt),
    .mendd_o (mendd), .bcfg1_o (bcfg1), .bcfg2_o (bcfg2), .bcfg3_o (bcfg3),
    .cprm1_o (cprm1), .stats_o (stats)
  );

endmodule

// ==== tb_aether_ctrl.sv ====
`timescale 1ns/1ps

module tb_aether_ctrl
  import aether_isa_pkg::*;
  import aether_reg_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 5;
  localparam int ACK_WAIT   = 8;
  // Upper bound on commands over all tests
  localparam int MAX_CMDS   = 100;
  localparam int WATCHDOG_CYCLES = MAX_CMDS * 20 + RST_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  logic        req;
  opcode_e     instr;
  logic [3:0]  param1;
  logic [15:0] param2;
  logic        ack;
  logic [15:0] rdata;
  logic        err;
  logic        cnv_done;
  logic        dns_done;
  logic        ldw_done;
  // rst cwgt..full [14:9], ldw cwgt..move [8:4], cnv [3], dns [2], lip strt/cont [1:0]
  logic [14:0] pulse_vec;
  logic [19:0] cnv_addr;
  logic [19:0] dns_addr;
  mem_cmd_e    mem_cmd;

  // Expected response of the command in flight
  logic [14:0] exp_pulses;
  mem_cmd_e    exp_mem;
  logic [19:0] exp_cnv_addr;
  logic [19:0] exp_dns_addr;
  logic [15:0] exp_rdata;
  logic        exp_err;
  string       test_name;
  logic [31:0] lfsr;
  // Register model by index
  logic [15:0] shadow [16];

  aether_ctrl_top i_aether_ctrl_top (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (req), .instr_i (instr),
    .param1_i (param1), .param2_i (param2), .ack_o (ack), .rdata_o (rdata), .err_o (err),
    .cnv_done_i (cnv_done), .dns_done_i (dns_done), .ldw_done_i (ldw_done),
    .rst_cwgt_o (pulse_vec[14]), .rst_conv_o (pulse_vec[13]), .rst_dwgt_o (pulse_vec[12]),
    .rst_dens_o (pulse_vec[11]), .rst_regs_o (pulse_vec[10]), .rst_full_o (pulse_vec[9]),
    .ldw_cwgt_o (pulse_vec[8]), .ldw_dwgt_o (pulse_vec[7]), .ldw_strt_o (pulse_vec[6]),
    .ldw_cont_o (pulse_vec[5]), .ldw_move_o (pulse_vec[4]),
    .cnv_run_o (pulse_vec[3]), .cnv_save_addr_o (cnv_addr),
    .dns_run_o (pulse_vec[2]), .dns_save_addr_o (dns_addr),
    .lip_strt_o (pulse_vec[1]), .lip_cont_o (pulse_vec[0]), .mem_command_o (mem_cmd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  // --------------------
  // Checks
  // --------------------
  a_reset_idle: assert property (@(posedge clk) !rst_n |=>
    (!ack && !err && rdata == 16'h0 && pulse_vec == '0 && mem_cmd == MEM_IDLE))
    else fail_now("outputs not idle after reset");
  // First high ack two edges after the accept edge
  a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(req, 2) && !$past(req, 3)) |-> (ack && !$past(ack)))
    else fail_now("ack_o did not rise two edges after the request was accepted");
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n) (ack && req) |=> ack)
    else fail_now("ack_o dropped while req_i was still high");
  a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n) (ack && !req) |=> !ack)
    else fail_now("ack_o did not fall on the first edge with req_i low");
  a_pulse_once: assert property (@(posedge clk) disable iff (!rst_n)
    (pulse_vec != '0) |=> (pulse_vec == '0))
    else fail_now("an action pulse lasted longer than one cycle");
  // Pulses only in the cycle after accept
  a_pulse_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
    (pulse_vec != '0 || mem_cmd != MEM_IDLE) |-> ($past(req) && !$past(req, 2)))
    else fail_now("action pulse or memory command outside a handshake");
  a_exec_pulses: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(req) && !$past(req, 2)) |-> (pulse_vec == exp_pulses))
    else fail_now($sformatf("ERR %s pulses expected %h actual %h",
                            test_name, exp_pulses, $sampled(pulse_vec)));
  a_exec_mem: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(req) && !$past(req, 2)) |-> (mem_cmd == exp_mem))
    else fail_now($sformatf("ERR %s mem_command expected %0d actual %0d",
                            test_name, exp_mem, $sampled(mem_cmd)));
  a_exec_cnv_addr: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(req) && !$past(req, 2)) |-> (cnv_addr == exp_cnv_addr))
    else fail_now($sformatf("ERR %s cnv addr expected %h actual %h",
                            test_name, exp_cnv_addr, $sampled(cnv_addr)));
  a_exec_dns_addr: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(req) && !$past(req, 2)) |-> (dns_addr == exp_dns_addr))
    else fail_now($sformatf("ERR %s dns addr expected %h actual %h",
                            test_name, exp_dns_addr, $sampled(dns_addr)));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> (rdata == exp_rdata))
    else fail_now($sformatf("ERR %s rdata expected %h actual %h",
                            test_name, exp_rdata, $sampled(rdata)));
  a_err: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> (err == exp_err))
    else fail_now($sformatf("ERR %s err expected %b actual %b",
                            test_name, exp_err, $sampled(err)));

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      // Fibonacci taps 32 22 2 1
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] done_bits(input logic [2:0] m);
    logic [15:0] v;
    v = '0;
    v[STATS_CNV_BIT] = m[0];
    v[STATS_DNS_BIT] = m[1];
    v[STATS_LDW_BIT] = m[2];
    return v;
  endfunction

  function automatic void load_defaults();
    shadow[REG_MEMUP] = RESET_DEFAULT_MEMUP;
    shadow[REG_MSTRT] = RESET_DEFAULT_MSTRT;
    shadow[REG_MENDD] = RESET_DEFAULT_MENDD;
    shadow[REG_BCFG1] = RESET_DEFAULT_BCFG1;
    shadow[REG_BCFG2] = RESET_DEFAULT_BCFG2;
    shadow[REG_BCFG3] = RESET_DEFAULT_BCFG3;
    shadow[REG_CPRM1] = RESET_DEFAULT_CPRM1;
    shadow[REG_STATS] = RESET_DEFAULT_STATS;
  endfunction

  function automatic logic [15:0] read_model(input logic [3:0] idx);
    if (idx == REG_VERSN) return VERSION_VAL;
    if (idx == REG_HWRID) return HWID_VAL;
    if (idx > 4'd9) return 16'h0000;
    return shadow[idx];
  endfunction

  function automatic logic expected_err(input opcode_e op, input logic [3:0] p1);
    case (op)
      RST:     return p1 > 4'd5;
      RDR:     return p1 > 4'd9;
      WRR:     return p1 == REG_VERSN || p1 == REG_HWRID || p1 > 4'd9;
      LDW:     return p1 > 4'd4;
      LIP:     return p1 > 4'd1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [14:0] expected_pulses(input opcode_e op, input logic [3:0] p1);
    logic [14:0] v;
    v = '0;
    if (op == RST) begin
      // Full and unknown targets hit every block
      if (p1 >= 4'd1 && p1 <= 4'd5) v[15 - p1] = 1'b1;
      else v[14:9] = 6'h3f;
    end
    if (op == LDW && p1 <= 4'd4) v[8 - p1] = 1'b1;
    if (op == CNV) v[3] = 1'b1;
    if (op == DNS) v[2] = (p1 == 4'd0);
    if (op == LIP && p1 <= 4'd1) v[1 - p1] = 1'b1;
    return v;
  endfunction

  function automatic mem_cmd_e expected_mem(input opcode_e op, input logic [3:0] p1);
    if (op == LDW && (p1 == LDW_CWGT || p1 == LDW_DWGT)) return MEM_READ;
    if (op == LDW && p1 == LDW_MOVE) return MEM_WRITE;
    if (op == CNV && shadow[REG_CPRM1][CPRM1_SAVE_BIT]) return MEM_WRITE;
    if (op == DNS) return MEM_WRITE;
    return MEM_IDLE;
  endfunction

  function automatic void update_model(input opcode_e op, input logic [3:0] p1,
                                       input logic [15:0] p2, input logic [2:0] done_exec);
    if (op == WRR && !expected_err(op, p1)) shadow[p1] = p2;
    if (op == RST && (p1 == RST_REGS || p1 == RST_FULL || p1 > 4'd5)) load_defaults();
    if (op == RDR && p1 == REG_STATS) shadow[REG_STATS] = shadow[REG_STATS] & ~done_bits(3'b111);
    // Done event beats the clear
    shadow[REG_STATS] = shadow[REG_STATS] | done_bits(done_exec);
  endfunction

  // --------------------
  // Host side
  // --------------------
  task automatic send_cmd(input opcode_e op, input logic [3:0] p1, input logic [15:0] p2,
                          input logic [2:0] done_exec, output logic [15:0] rd, output logic er);
    int waited;
    exp_pulses   = expected_pulses(op, p1);
    exp_mem      = expected_mem(op, p1);
    exp_err      = expected_err(op, p1);
    exp_cnv_addr = (op == CNV) ? {p1, p2} : 20'd0;
    exp_dns_addr = (op == DNS && p1 == 4'd0) ? {p1, p2} : 20'd0;
    // Done pulse in EXEC shows in this read
    shadow[REG_STATS] = shadow[REG_STATS] | done_bits(done_exec);
    exp_rdata = (op == RDR) ? read_model(p1) : shadow[REG_STATS];
    instr  = op;
    param1 = p1;
    param2 = p2;
    req    = 1'b1;
    @(posedge clk);
    #1;
    {ldw_done, dns_done, cnv_done} = done_exec;
    @(posedge clk);
    #1;
    {ldw_done, dns_done, cnv_done} = 3'b000;
    waited = 0;
    while (!ack && waited < ACK_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ack) fail_now("ack_o never rose for the issued command");
    rd  = rdata;
    er  = err;
    // Host keeps req up one more edge while ack is high
    @(posedge clk);
    #1;
    req = 1'b0;
    waited = 0;
    while (ack && waited < ACK_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (ack) fail_now("ack_o stayed high after req_i was dropped");
    update_model(op, p1, p2, done_exec);
  endtask

  task automatic issue(input opcode_e op, input logic [3:0] p1, input logic [15:0] p2);
    logic [15:0] rd;
    logic        er;
    send_cmd(op, p1, p2, 3'b000, rd, er);
  endtask

  // Engine done event between commands
  task automatic pulse_done(input logic [2:0] m);
    shadow[REG_STATS] = shadow[REG_STATS] | done_bits(m);
    {ldw_done, dns_done, cnv_done} = m;
    @(posedge clk);
    #1;
    {ldw_done, dns_done, cnv_done} = 3'b000;
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < 10; i++) issue(RDR, 4'(i), 16'h0000);
  endtask

  task automatic write_random_regs();
    logic [31:0] rnd;
    for (int i = 2; i < 9; i++) begin
      rnd = rand_bits(16);
      issue(WRR, 4'(i), rnd[15:0]);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_register_access();
    logic [31:0] rnd;
    test_name = "reg_access";
    write_random_regs();
    read_all_regs();
    test_name = "reg_readonly";
    rnd = rand_bits(16);
    issue(WRR, REG_VERSN, rnd[15:0]);
    issue(WRR, REG_HWRID, ~rnd[15:0]);
    issue(WRR, 4'hc, rnd[15:0]);
    read_all_regs();
    test_name = "reg_invalid_read";
    issue(RDR, 4'hb, 16'h0000);
  endtask

  task automatic test_resets();
    test_name = "rst_single";
    write_random_regs();
    for (int s = 1; s < 5; s++) issue(RST, 4'(s), 16'h0000);
    test_name = "rst_regs";
    issue(RST, RST_REGS, 16'h0000);
    read_all_regs();
    test_name = "rst_full";
    issue(RST, RST_FULL, 16'h0000);
    test_name = "rst_unknown";
    issue(RST, 4'h9, 16'h0000);
  endtask

  task automatic test_status();
    logic [15:0] rd;
    logic        er;
    test_name = "stats_sticky";
    pulse_done(3'b111);
    issue(RDR, REG_STATS, 16'h0000);
    issue(RDR, REG_STATS, 16'h0000);
    test_name = "stats_same_cycle";
    pulse_done(3'b001);
    send_cmd(RDR, REG_STATS, 16'h0000, 3'b010, rd, er);
    issue(RDR, REG_STATS, 16'h0000);
    issue(RDR, REG_STATS, 16'h0000);
  endtask

  task automatic test_engine_cmds();
    logic [31:0] rnd;
    logic [15:0] save_on;
    test_name = "ldw";
    for (int s = 0; s < 6; s++) issue(LDW, 4'(s), 16'h0000);
    test_name = "lip";
    for (int s = 0; s < 3; s++) issue(LIP, 4'(s), 16'h0000);
    test_name = "cnv";
    save_on = '0;
    save_on[CPRM1_SAVE_BIT] = 1'b1;
    issue(WRR, REG_CPRM1, 16'h0000);
    rnd = rand_bits(20);
    issue(CNV, rnd[19:16], rnd[15:0]);
    issue(WRR, REG_CPRM1, save_on);
    rnd = rand_bits(20);
    issue(CNV, rnd[19:16], rnd[15:0]);
    test_name = "dns";
    rnd = rand_bits(16);
    issue(DNS, 4'h0, rnd[15:0]);
    rnd = rand_bits(16);
    issue(DNS, 4'h3, rnd[15:0]);
  endtask

  initial begin
    rst_n    = 1'b0;
    req      = 1'b0;
    instr    = NOP;
    param1   = 4'h0;
    param2   = 16'h0000;
    cnv_done = 1'b0;
    dns_done = 1'b0;
    ldw_done = 1'b0;
    exp_pulses   = '0;
    exp_mem      = MEM_IDLE;
    exp_cnv_addr = '0;
    exp_dns_addr = '0;
    exp_rdata    = '0;
    exp_err      = 1'b0;
    test_name    = "reset";
    lfsr         = 32'hbcef;
    load_defaults();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_register_access();
    test_resets();
    test_status();
    test_engine_cmds();
    repeat (4) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

  // Bounded by the command budget
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_now("watchdog expired before the tests finished");
  end

endmodule

// ==== compile.f ====
aether_isa_pkg.sv
aether_reg_pkg.sv
aether_cmd_frontend.sv
aether_instr_decoder.sv
aether_reg_file.sv
aether_ctrl_top.sv
tb_aether_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_aether_ctrl -f compile.f -o tb_aether_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

# Simulator exit status carries the result
./obj_dir/tb_aether_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
